// File: Makefile
SIM := obj_dir/Vtb_chain_processor

.PHONY: all run clean

all: run

$(SIM): sim.f $(wildcard hw/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_chain_processor -f sim.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

// File: hw/chain_control.sv
// execute stage, applies commands to chain identity and acquisition settings and forwards them
`timescale 1ns/1ps

module chain_control import chain_pkg::*; #(
	parameter int RAM_AW = chain_pkg::RAM_AW
) (
	input  logic       clk,
	input  logic       rst_n,
	input  cmd_t       cmd,
	input  logic       cmd_valid,
	input  logic       rearm,         // end of readout with autorearm
	output chain_t     chain,
	output acq_cfg_t   cfg,
	output logic [7:0] com_data,      // byte to the next board
	output logic       new_com_data,
	output logic       prime_trigger,
	output logic       start_readout,
	output logic       start_id
);

	localparam int TP_MIN = 4;
	localparam int TP_MAX = 2**RAM_AW - 16; // keep room after the trigger

	logic              fwd_en;    // this command goes down the chain
	logic [7:0]        fwd_byte;  // first byte sent down
	logic [15:0]       fwd_buf;   // args still to be sent, msb first
	logic [1:0]        fwd_cnt;
	logic              prime_q;
	logic              sel_hit;   // 10+id addressed to us
	logic              kept;
	logic [15:0]       arg16;
	logic [RAM_AW-1:0] tp_clamped;
	logic [RAM_AW-1:0] nsmp_new;

	assign arg16    = {cmd.arg0, cmd.arg1};
	assign nsmp_new = RAM_AW'(arg16);
	assign sel_hit  = (cmd.opcode - OP_SELECT) == chain.my_id;
	assign kept     = (cmd.opcode < 8'd40) || (cmd.opcode inside {OP_PRIME, OP_ROLL_ON,
		OP_ROLL_OFF, OP_TRIG_POINT, OP_NSMP, OP_SEND_INC, OP_PACE, OP_THRESH,
		OP_TRIG_TYPE, OP_TRIG_CHAN, OP_AUTOREARM, OP_CHIP_ID, OP_BLOCKS});

	always_comb begin
		if (arg16 > 16'(TP_MAX))
			tp_clamped = RAM_AW'(TP_MAX);
		else if (arg16 < 16'(TP_MIN))
			tp_clamped = RAM_AW'(TP_MIN);
		else
			tp_clamped = RAM_AW'(arg16);
	end

	always_comb begin
		fwd_en   = kept;
		fwd_byte = cmd.opcode;
		if (cmd.opcode < OP_SELECT)
			fwd_byte = cmd.opcode + 8'd1; // next board gets the next id
		else if (cmd.opcode < OP_LAST && sel_hit)
			fwd_en = 1'b0; // our own readout
		else if (cmd.opcode == OP_CHIP_ID && !chain.passthrough)
			fwd_en = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chain         <= '{my_id: 8'd200, passthrough: 1'b0, is_last: 1'b0,
				master_clock: 2'b00};
			cfg           <= '{trigger_point: RAM_AW'(2**(RAM_AW-2)), nsmp: '0,
				send_shift: 4'd0, pace_bits: 5'd5, blocks: 3'd4, trig_thresh: 8'h80,
				trig_type: 4'd1, trig_chans: 4'hf, rolling: 1'b1, autorearm: 1'b0};
			new_com_data  <= 1'b0;
			fwd_cnt       <= 2'd0;
			prime_q       <= 1'b0;
			start_readout <= 1'b0;
			start_id      <= 1'b0;
		end else begin
			new_com_data  <= 1'b0;
			prime_q       <= 1'b0;
			start_readout <= 1'b0;
			start_id      <= 1'b0;
			if (cmd_valid) begin
				new_com_data <= fwd_en;
				fwd_cnt      <= fwd_en ? arg_count(cmd.opcode) : 2'd0;
				if (cmd.opcode < OP_SELECT) begin
					chain.my_id        <= cmd.opcode;
					chain.master_clock <= (cmd.opcode == 8'd0) ? 2'b00 : 2'b01;
				end else if (cmd.opcode < OP_LAST) begin
					chain.passthrough <= !sel_hit;
					start_readout     <= sel_hit;
				end else if (cmd.opcode < OP_ACTIVE) begin
					chain.is_last <= (cmd.opcode - OP_LAST) == chain.my_id;
				end else if (cmd.opcode < 8'd40) begin
					chain.passthrough <= (cmd.opcode - OP_ACTIVE) != chain.my_id;
				end else begin
					case (cmd.opcode)
						OP_PRIME:      prime_q <= 1'b1;
						OP_ROLL_ON:    cfg.rolling <= 1'b1;
						OP_ROLL_OFF:   cfg.rolling <= 1'b0;
						OP_TRIG_POINT: cfg.trigger_point <= tp_clamped;
						OP_NSMP: begin
							cfg.nsmp <= nsmp_new;
							// trigger has to sit inside the window we send
							if (nsmp_new >= RAM_AW'(5) &&
								cfg.trigger_point > nsmp_new - RAM_AW'(5))
								cfg.trigger_point <= nsmp_new >> 1;
						end
						OP_SEND_INC:   cfg.send_shift <= cmd.arg0[3:0];
						OP_PACE:       cfg.pace_bits <= (cmd.arg0 > 8'd30) ? 5'd30 : cmd.arg0[4:0];
						OP_THRESH:     cfg.trig_thresh <= cmd.arg0;
						OP_TRIG_TYPE:  cfg.trig_type <= cmd.arg0[3:0];
						OP_TRIG_CHAN: begin
							if ({2'b00, cmd.arg0[7:2]} == chain.my_id) // our channel
								cfg.trig_chans[cmd.arg0[1:0]] <= ~cfg.trig_chans[cmd.arg0[1:0]];
						end
						OP_AUTOREARM:  cfg.autorearm <= ~cfg.autorearm;
						OP_CHIP_ID:    start_id <= !chain.passthrough;
						OP_BLOCKS:     cfg.blocks <= cmd.arg0[2:0];
						default: ; // ignored opcode
					endcase
				end
			end else if (fwd_cnt != 2'd0) begin
				new_com_data <= 1'b1; // next argument strobe
				fwd_cnt      <= fwd_cnt - 2'd1;
			end
		end
	end

	// forwarded byte shifter
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			com_data <= fwd_byte;
			fwd_buf  <= arg16;
		end else if (fwd_cnt != 2'd0) begin
			com_data <= fwd_buf[15:8];
			fwd_buf  <= {fwd_buf[7:0], 8'h00};
		end
	end

	assign prime_trigger = prime_q | rearm; // host prime or autorearm

	a_one_reply: assert property (@(posedge clk) disable iff (!rst_n)
		!(start_readout && start_id))
		else $error("readout and id reply started together");

endmodule

// File: hw/chain_pkg.sv
// chain processor package with shared types, opcodes and the argument-count table
package chain_pkg;

	localparam int RAM_AW    = 12; // capture ram address width, 4096 samples
	localparam int MAX_LANES = 5;  // four scope channels plus the logic buffer

	// kept opcodes, the four id-style commands are range bases
	typedef enum logic [7:0] {
		OP_SET_ID     = 8'd0,   // 0..9 assign board id
		OP_SELECT     = 8'd10,  // 10..19 select board for readout
		OP_LAST       = 8'd20,  // 20..29 mark last board
		OP_ACTIVE     = 8'd30,  // 30..39 make board active
		OP_PRIME      = 8'd100,
		OP_ROLL_ON    = 8'd101,
		OP_ROLL_OFF   = 8'd102,
		OP_TRIG_POINT = 8'd121, // two bytes, msb first
		OP_NSMP       = 8'd122, // two bytes, msb first
		OP_SEND_INC   = 8'd123, // log2 of sample step
		OP_PACE       = 8'd125, // log2 of ticks between bytes
		OP_THRESH     = 8'd127,
		OP_TRIG_TYPE  = 8'd128,
		OP_TRIG_CHAN  = 8'd130, // 4*board + channel
		OP_AUTOREARM  = 8'd139,
		OP_CHIP_ID    = 8'd142,
		OP_BLOCKS     = 8'd145
	} op_e;

	// one decoded command, args that were not sent read as zero
	typedef struct packed {
		logic [7:0] opcode;
		logic [7:0] arg0;
		logic [7:0] arg1;
	} cmd_t;

	// identity of this board in the daisy chain
	typedef struct packed {
		logic [7:0] my_id;
		logic       passthrough;  // serial output belongs to a board further down
		logic       is_last;
		logic [1:0] master_clock; // 0 own master, 1 slave
	} chain_t;

	typedef struct packed {
		logic [RAM_AW-1:0] trigger_point;
		logic [RAM_AW-1:0] nsmp;       // samples per block
		logic [3:0]        send_shift; // step 2**send_shift
		logic [4:0]        pace_bits;
		logic [2:0]        blocks;
		logic [7:0]        trig_thresh;
		logic [3:0]        trig_type;
		logic [3:0]        trig_chans;
		logic              rolling;
		logic              autorearm;
	} acq_cfg_t;

	typedef logic [MAX_LANES-1:0][7:0] lanes_t; // lane k is block k

	// argument bytes that follow each opcode
	function automatic logic [1:0] arg_count(input logic [7:0] op);
		case (op)
			OP_TRIG_POINT, OP_NSMP: return 2'd2;
			OP_SEND_INC, OP_PACE, OP_THRESH,
			OP_TRIG_TYPE, OP_TRIG_CHAN, OP_BLOCKS: return 2'd1;
			default: return 2'd0; // includes every ignored opcode
		endcase
	endfunction

endpackage

// File: hw/chain_processor.sv
// daisy-chain command processor top, decode then execute then transmit
`timescale 1ns/1ps

module chain_processor import chain_pkg::*; #(
	parameter int RAM_AW         = chain_pkg::RAM_AW,
	parameter int TIMEOUT_CYCLES = 100_000_000
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              rx_ready,
	input  logic [7:0]        rx_data,
	input  logic              tx_busy,
	input  logic              ext_data_ready,
	input  logic [RAM_AW-1:0] wr_trig_addr,
	input  lanes_t            ram_data,
	input  logic [63:0]       chip_id,
	output logic              tx_start,
	output logic [7:0]        tx_data,
	output logic              new_com_data,
	output logic [7:0]        com_data,
	output logic              prime_trigger,
	output chain_t            chain,
	output acq_cfg_t          cfg,
	output logic [RAM_AW-1:0] rd_addr,
	output logic              rd_en
);

	cmd_t cmd;
	logic cmd_valid;
	logic start_readout; // this board was selected
	logic start_id;
	logic busy;          // readout or id reply running
	logic rearm;

	cmd_decode u_decode (
		.clk, .rst_n, .rx_ready, .rx_data, .busy, .cmd, .cmd_valid
	);

	chain_control #(.RAM_AW(RAM_AW)) u_control (
		.clk, .rst_n, .cmd, .cmd_valid, .rearm, .chain, .cfg, .com_data,
		.new_com_data, .prime_trigger, .start_readout, .start_id
	);

	tx_sequencer #(.RAM_AW(RAM_AW), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_tx (
		.clk, .rst_n, .cfg, .start_readout, .start_id, .ext_data_ready, .wr_trig_addr,
		.ram_data, .chip_id, .tx_busy, .tx_start, .tx_data, .rd_addr, .rd_en,
		.busy, .rearm
	);

endmodule

// File: hw/cmd_decode.sv
// command decoder, gathers an opcode and its argument bytes into one command record
`timescale 1ns/1ps

module cmd_decode import chain_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx_ready, // one-cycle strobe from the uart receiver
	input  logic [7:0] rx_data,
	input  logic       busy,     // readout in progress, bytes are dropped
	output cmd_t       cmd,
	output logic       cmd_valid
);

	typedef enum logic {
		S_IDLE,    // waiting for an opcode
		S_COLLECT  // gathering argument bytes
	} state_e;

	state_e     state;
	logic [1:0] need;   // args still expected for this opcode, 1 or 2
	logic       idx;    // next argument slot
	logic       take;   // a byte we actually accept
	logic [1:0] n_args; // args of the byte on rx_data

	assign take   = rx_ready && !busy;
	assign n_args = arg_count(rx_data);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			need      <= 2'd0;
			idx       <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= 1'b0; // pulse only
			case (state)
				S_IDLE: begin
					if (take) begin
						need <= n_args;
						idx  <= 1'b0;
						if (n_args == 2'd0)
							cmd_valid <= 1'b1; // opcode alone is the last byte
						else
							state <= S_COLLECT;
					end
				end
				S_COLLECT: begin
					if (take) begin
						idx <= 1'b1;
						// idx counts bytes already stored
						if ({1'b0, idx} + 2'd1 == need) begin
							cmd_valid <= 1'b1;
							state     <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// the record itself
	always_ff @(posedge clk) begin
		if (take) begin
			if (state == S_IDLE) begin
				cmd.opcode <= rx_data;
				cmd.arg0   <= 8'h00; // cleared so short commands read zero
				cmd.arg1   <= 8'h00;
			end else if (!idx) begin
				cmd.arg0 <= rx_data;
			end else begin
				cmd.arg1 <= rx_data;
			end
		end
	end

	// a record is handed over exactly once
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |=> !cmd_valid)
		else $error("cmd_valid held for two cycles");

endmodule

// File: hw/tx_sequencer.sv
// result stage, paces capture ram blocks or the chip id out through the uart transmitter
`timescale 1ns/1ps

module tx_sequencer import chain_pkg::*; #(
	parameter int RAM_AW         = chain_pkg::RAM_AW,
	parameter int TIMEOUT_CYCLES = 100_000_000
) (
	input  logic              clk,
	input  logic              rst_n,
	input  acq_cfg_t          cfg,
	input  logic              start_readout,
	input  logic              start_id,
	input  logic              ext_data_ready, // capture complete
	input  logic [RAM_AW-1:0] wr_trig_addr,
	input  lanes_t            ram_data,       // valid one cycle after rd_addr
	input  logic [63:0]       chip_id,
	input  logic              tx_busy,
	output logic              tx_start,
	output logic [7:0]        tx_data,
	output logic [RAM_AW-1:0] rd_addr,
	output logic              rd_en,
	output logic              busy,
	output logic              rearm
);

	localparam int TW = $clog2(TIMEOUT_CYCLES + 1);
	localparam int CW = RAM_AW + 16; // sample count incl. the largest step

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT,   // wait for ext_data_ready
		S_FETCH,  // ram sees the new address
		S_SEND,
		S_ID,
		S_ID_GAP  // transmitter raises busy here
	} state_e;

	state_e            state;
	logic [31:0]       pace_cnt;  // free running
	logic              pace_bit;
	logic              pace_ref;  // pace bit at the last byte
	logic [TW-1:0]     to_cnt;
	logic [2:0]        blk;       // block, also the lane
	logic [CW-1:0]     samp_cnt;  // offset in the block
	logic [CW-1:0]     next_samp;
	logic              block_end;
	logic [RAM_AW-1:0] block_base;
	logic [RAM_AW-1:0] addr_step;
	logic [7:0]        lane_byte;
	logic              send_ok;
	logic              id_ok;
	logic [2:0]        id_idx;
	logic [63:0]       id_sr;     // chip id, lsb out first

	assign pace_bit   = pace_cnt[cfg.pace_bits];
	assign next_samp  = samp_cnt + (CW'(1) << cfg.send_shift);
	assign block_end  = next_samp >= CW'(cfg.nsmp);
	assign block_base = wr_trig_addr - cfg.trigger_point;
	assign addr_step  = RAM_AW'(1) << cfg.send_shift;
	assign lane_byte  = (blk < MAX_LANES) ? ram_data[blk] : 8'h00;
	assign send_ok    = (state == S_SEND) && !tx_busy && (pace_bit != pace_ref);
	assign id_ok      = (state == S_ID) && !tx_busy;
	assign busy       = (state != S_IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			pace_cnt <= '0;
			pace_ref <= 1'b0;
			to_cnt   <= '0;
			blk      <= 3'd0;
			samp_cnt <= '0;
			id_idx   <= 3'd0;
			tx_start <= 1'b0;
			rd_en    <= 1'b0;
			rearm    <= 1'b0;
		end else begin
			pace_cnt <= pace_cnt + 32'd1;
			tx_start <= 1'b0;
			rearm    <= 1'b0;
			case (state)
				S_IDLE: begin
					to_cnt <= '0;
					if (start_readout) begin
						state <= S_WAIT;
					end else if (start_id) begin
						id_idx <= 3'd0;
						state  <= S_ID;
					end
				end
				S_WAIT: begin
					if (ext_data_ready) begin
						blk      <= 3'd0;
						samp_cnt <= '0;
						pace_ref <= pace_bit; // first byte waits for a toggle
						if (cfg.nsmp == '0 || cfg.blocks == 3'd0) begin
							rearm <= cfg.autorearm; // nothing to send
							state <= S_IDLE;
						end else begin
							rd_en <= 1'b1;
							state <= S_FETCH;
						end
					end else if (to_cnt == TW'(TIMEOUT_CYCLES - 1)) begin
						state <= S_IDLE; // give up, no bytes
					end else begin
						to_cnt <= to_cnt + 1'b1;
					end
				end
				S_FETCH: state <= S_SEND;
				S_SEND: begin
					if (send_ok) begin
						tx_start <= 1'b1;
						pace_ref <= pace_bit;
						state    <= S_FETCH;
						if (!block_end) begin
							samp_cnt <= next_samp;
						end else if (blk + 3'd1 == cfg.blocks) begin
							samp_cnt <= '0;
							rd_en    <= 1'b0;
							rearm    <= cfg.autorearm;
							state    <= S_IDLE;
						end else begin
							samp_cnt <= '0;
							blk      <= blk + 3'd1; // next lane
						end
					end
				end
				S_ID: begin
					if (id_ok) begin
						tx_start <= 1'b1;
						id_idx   <= id_idx + 3'd1;
						state    <= (id_idx == 3'd7) ? S_IDLE : S_ID_GAP;
					end
				end
				S_ID_GAP: state <= S_ID;
				default:  state <= S_IDLE;
			endcase
		end
	end

	// address walk and outgoing byte
	always_ff @(posedge clk) begin
		if (state == S_WAIT) begin
			rd_addr <= block_base;
		end else if (send_ok) begin
			tx_data <= lane_byte;
			rd_addr <= block_end ? block_base : rd_addr + addr_step;
		end
		if (state == S_IDLE && start_id) begin
			id_sr <= chip_id;
		end else if (id_ok) begin
			tx_data <= id_sr[7:0];
			id_sr   <= id_sr >> 8;
		end
	end

	// transmitter must have been idle when the start was decided
	a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |-> !$past(tx_busy))
		else $error("tx_start issued against a busy transmitter");

	a_tx_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |=> !tx_start)
		else $error("tx_start longer than one cycle");

endmodule

// File: sim.f
hw/chain_pkg.sv
hw/cmd_decode.sv
hw/chain_control.sv
hw/tx_sequencer.sv
hw/chain_processor.sv
test/capture_ram_model.sv
test/tb_chain_processor.sv

// File: test/capture_ram_model.sv
// capture ram model, five read lanes with a registered read over a fixed fill pattern
`timescale 1ns/1ps

module capture_ram_model import chain_pkg::*; #(
	parameter int RAM_AW = chain_pkg::RAM_AW
) (
	input  logic              clk,
	input  logic              rd_en,
	input  logic [RAM_AW-1:0] rd_addr,
	output lanes_t            ram_data  // one cycle after rd_addr
);

	logic [7:0] mem [MAX_LANES][2**RAM_AW];

	// whole address xor-folded into five bits, five address bits per step
	function automatic logic [4:0] addr_fold(input logic [RAM_AW-1:0] a);
		logic [4:0] f;
		f = '0;
		for (int i = 0; i < RAM_AW; i += 5)
			f ^= 5'(a >> i);
		return f;
	endfunction

	// lane number in the top three bits, so a wrong lane shows at once
	initial begin
		for (int k = 0; k < MAX_LANES; k++) begin
			for (int a = 0; a < 2**RAM_AW; a++)
				mem[k][a] = {3'(k), addr_fold(RAM_AW'(a))};
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int k = 0; k < MAX_LANES; k++)
				ram_data[k] <= mem[k][rd_addr]; // all lanes read in parallel
		end
	end

endmodule

// File: test/tb_chain_processor.sv
// testbench for the chain processor, serial commands in, forwarded bytes and uart replies checked
`timescale 1ns/1ps

module tb_chain_processor import chain_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000; // short capture wait
	localparam int TP_MAX         = 2**RAM_AW - 16;
	localparam int MY_ID          = 3;

	logic              clk;
	logic              rst_n;
	logic              rx_ready;
	logic [7:0]        rx_data;
	logic              tx_busy;
	logic              ext_data_ready;
	logic [RAM_AW-1:0] wr_trig_addr;
	lanes_t            ram_data;
	logic [63:0]       chip_id;
	logic              tx_start;
	logic [7:0]        tx_data;
	logic              new_com_data;
	logic [7:0]        com_data;
	logic              prime_trigger;
	chain_t            chain;
	acq_cfg_t          cfg;
	logic [RAM_AW-1:0] rd_addr;
	logic              rd_en;

	logic [7:0]  tx_q[$];   // bytes seen by the uart model
	logic [7:0]  fwd_q[$];  // bytes sent down the chain
	int          fwd_cyc[$];
	int          cyc = 0;
	int          rx_cyc = 0; // cycle of the last sampled rx strobe
	int          tx_hold = 0;
	int          prime_cnt = 0;
	int          errors = 0;
	int          timeouts = 0;
	int          exp_tp;
	int          exp_nsmp;
	int          exp_step;
	logic [31:0] rng_state;

	chain_processor #(.RAM_AW(RAM_AW), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_dut (.*);
	capture_ram_model #(.RAM_AW(RAM_AW)) u_ram (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// uart transmitter, busy for three cycles after each start
	always @(posedge clk) begin
		if (tx_start) begin
			tx_q.push_back(tx_data);
			tx_hold = 3;
		end else if (tx_hold > 0) begin
			tx_hold--;
		end
		#1 tx_busy = (tx_hold > 0);
	end

	always @(posedge clk) begin
		cyc++;
		if (rx_ready)
			rx_cyc = cyc;
		if (new_com_data) begin
			fwd_q.push_back(com_data);
			fwd_cyc.push_back(cyc);
		end
		if (prime_trigger)
			prime_cnt++;
	end

	a_prime_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		prime_trigger |=> !prime_trigger)
		else begin
			errors++;
			$display("[ERROR] %0t ns: prime_trigger held for two cycles", $time);
		end

	function automatic logic [7:0] rand_byte();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[23:16];
	endfunction

	function automatic int clamp_tp(input int v);
		if (v > TP_MAX)
			return TP_MAX;
		if (v < 4)
			return 4;
		return v;
	endfunction

	// lane in the top bits, the address folded five bits at a time below
	function automatic logic [7:0] lane_pattern(input int lane, input logic [RAM_AW-1:0] a);
		logic [RAM_AW-1:0] rest;
		logic [4:0]        low;
		rest = a;
		low  = '0;
		while (rest != '0) begin
			low  = low ^ rest[4:0];
			rest = rest >> 5;
		end
		return {lane[2:0], low};
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			errors++;
			$display("[ERROR] %0t ns: %s", $time, msg);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout at %0t ns while waiting for %s", $time, what);
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		#1;
		rx_ready = 1'b1;
		rx_data  = b;
		@(posedge clk);
		#1 rx_ready = 1'b0;
	endtask

	task automatic send_cmd(input logic [7:0] op, input int nargs, input logic [7:0] a0,
		input logic [7:0] a1);
		fwd_q.delete();
		fwd_cyc.delete();
		send_byte(op);
		if (nargs > 0)
			send_byte(a0);
		if (nargs > 1)
			send_byte(a1);
	endtask

	// opcode strobe two cycles after the last rx strobe, args right behind it
	task automatic expect_fwd(input logic [7:0] b0, input int nargs, input logic [7:0] a0,
		input logic [7:0] a1);
		logic [7:0] exp_b [3];
		int         t;
		exp_b = '{b0, a0, a1};
		t = 0;
		while (fwd_q.size() < nargs + 1 && t < 20) begin
			@(negedge clk);
			t++;
		end
		@(negedge clk);
		if (fwd_q.size() < nargs + 1) begin
			report_timeout($sformatf("forwarded bytes of command %0d", b0));
		end else begin
			check(fwd_q.size() == nargs + 1, "extra forwarded strobes");
			for (int i = 0; i <= nargs; i++) begin
				check(fwd_q[i] == exp_b[i], $sformatf("forwarded byte %0d is %0d, expected %0d",
					i, fwd_q[i], exp_b[i]));
				check(fwd_cyc[i] == rx_cyc + 2 + i, $sformatf("forwarded byte %0d off time", i));
			end
		end
	endtask

	task automatic fwd_cmd(input logic [7:0] op, input int nargs, input logic [7:0] a0,
		input logic [7:0] a1);
		send_cmd(op, nargs, a0, a1);
		expect_fwd(op, nargs, a0, a1);
	endtask

	task automatic expect_consumed();
		repeat (4) @(negedge clk); // a forward would show after two
		check(fwd_q.size() == 0, "command forwarded that this board should consume");
	endtask

	task automatic wait_reply(input int n, input int limit);
		int t;
		t = 0;
		while ((tx_q.size() < n || u_dut.busy) && t < limit) begin
			@(negedge clk);
			t++;
		end
		if (t == limit)
			report_timeout("uart reply to finish");
		check(tx_q.size() == n, $sformatf("%0d bytes sent, expected %0d", tx_q.size(), n));
	endtask

	task automatic select_self(input logic ready);
		@(posedge clk);
		#1 ext_data_ready = ready;
		tx_q.delete();
		prime_cnt = 0;
		send_cmd(8'(OP_SELECT + MY_ID), 0, 8'h00, 8'h00);
		expect_consumed();
	endtask

	task automatic run_readout(input int n_blocks, input logic rearm_on);
		logic [RAM_AW-1:0] base;
		int                per_blk;
		int                idx;
		base    = wr_trig_addr - RAM_AW'(exp_tp);
		per_blk = (exp_nsmp + exp_step - 1) / exp_step;
		select_self(1'b1);
		wait_reply(n_blocks * per_blk, 20000);
		idx = 0;
		for (int b = 0; b < n_blocks; b++) begin
			for (int s = 0; s < exp_nsmp; s += exp_step) begin
				if (idx < tx_q.size())
					check(tx_q[idx] == lane_pattern(b, base + RAM_AW'(s)),
						$sformatf("block %0d sample %0d read %02h", b, s, tx_q[idx]));
				idx++;
			end
		end
		check(prime_cnt == int'(rearm_on), "rearm pulse count after readout");
		check(!chain.passthrough, "selected board kept passthrough");
		check(!rd_en, "ram read enable left on after readout");
		@(posedge clk);
		#1 ext_data_ready = 1'b0;
	endtask

	initial begin
		logic [7:0] a0;
		logic [7:0] a1;
		int         t;
		rng_state      = 32'd24692;
		rst_n          = 1'b0;
		rx_ready       = 1'b0;
		rx_data        = 8'h00;
		tx_busy        = 1'b0;
		ext_data_ready = 1'b0;
		wr_trig_addr   = RAM_AW'(5); // block start wraps below zero
		chip_id        = 64'hc3a5_1f20_7e94_d60b;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		check(chain.my_id == 8'd200 && !chain.passthrough && !chain.is_last, "identity after reset");
		check(cfg.rolling && cfg.nsmp == '0 && cfg.blocks == 3'd4 && cfg.pace_bits == 5'd5 &&
			cfg.trigger_point == RAM_AW'(2**(RAM_AW-2)), "settings after reset");
		check(cfg.trig_thresh == 8'h80 && cfg.trig_type == 4'd1 && cfg.trig_chans == 4'hf,
			"trigger settings after reset");
		check(!tx_start && !new_com_data && !prime_trigger && !rd_en && !u_dut.busy,
			"outputs after reset");

		// id assignment, each board hands id+1 on
		send_cmd(8'(MY_ID), 0, 8'h00, 8'h00);
		expect_fwd(8'(MY_ID + 1), 0, 8'h00, 8'h00);
		check(chain.my_id == 8'(MY_ID) && chain.master_clock == 2'd1, "id 3 not taken as slave");
		send_cmd(8'd0, 0, 8'h00, 8'h00);
		expect_fwd(8'd1, 0, 8'h00, 8'h00);
		check(chain.my_id == 8'd0 && chain.master_clock == 2'd0, "id 0 not taken as master");
		send_cmd(8'(MY_ID), 0, 8'h00, 8'h00);
		expect_fwd(8'(MY_ID + 1), 0, 8'h00, 8'h00);
		check(chain.my_id == 8'(MY_ID), "id 3 not taken");

		a0 = rand_byte();
		fwd_cmd(OP_THRESH, 1, a0, 8'h00);
		check(cfg.trig_thresh == a0, "trigger threshold");
		a0 = rand_byte();
		fwd_cmd(OP_TRIG_TYPE, 1, a0, 8'h00);
		check(cfg.trig_type == a0[3:0], "trigger type");
		a0 = rand_byte() % 16;
		a1 = rand_byte();
		fwd_cmd(OP_TRIG_POINT, 2, a0, a1);
		exp_tp = clamp_tp({a0, a1});
		check(cfg.trigger_point == RAM_AW'(exp_tp), "trigger point in range");
		a1 = rand_byte();
		fwd_cmd(OP_TRIG_POINT, 2, 8'hff, a1);
		exp_tp = clamp_tp({8'hff, a1});
		check(cfg.trigger_point == RAM_AW'(TP_MAX), "trigger point upper clamp");
		exp_nsmp = 16 + rand_byte() % 32;
		fwd_cmd(OP_NSMP, 2, 8'h00, 8'(exp_nsmp));
		if (exp_nsmp >= 5 && exp_tp > exp_nsmp - 5)
			exp_tp = exp_nsmp / 2; // trigger pulled back into the window
		check(cfg.nsmp == RAM_AW'(exp_nsmp), "sample count");
		check(cfg.trigger_point == RAM_AW'(exp_tp), "trigger point after sample count");
		fwd_cmd(OP_SEND_INC, 1, 8'd1, 8'h00);
		exp_step = 2;
		check(cfg.send_shift == 4'd1, "send increment");
		fwd_cmd(OP_PACE, 1, 8'd40, 8'h00);
		check(cfg.pace_bits == 5'd30, "pacing clamp");
		fwd_cmd(OP_PACE, 1, 8'd2, 8'h00);
		check(cfg.pace_bits == 5'd2, "pacing");
		fwd_cmd(OP_BLOCKS, 1, 8'd3, 8'h00);
		check(cfg.blocks == 3'd3, "block count");

		// channel toggles and flags
		fwd_cmd(OP_TRIG_CHAN, 1, 8'(4 * MY_ID + 2), 8'h00);
		check(cfg.trig_chans == 4'hb, "own channel 2 toggle");
		fwd_cmd(OP_TRIG_CHAN, 1, 8'(4 * 5 + 1), 8'h00);
		check(cfg.trig_chans == 4'hb, "channel toggle of another board changed this one");
		fwd_cmd(OP_ROLL_OFF, 0, 8'h00, 8'h00);
		check(!cfg.rolling, "rolling off");
		fwd_cmd(OP_ROLL_ON, 0, 8'h00, 8'h00);
		check(cfg.rolling, "rolling on");
		fwd_cmd(8'(OP_LAST + MY_ID), 0, 8'h00, 8'h00);
		check(chain.is_last, "last board flag");
		prime_cnt = 0;
		fwd_cmd(OP_PRIME, 0, 8'h00, 8'h00);
		check(prime_cnt == 1, "prime pulse count");

		// readouts, the second one with autorearm
		run_readout(3, 1'b0);
		fwd_cmd(OP_AUTOREARM, 0, 8'h00, 8'h00);
		check(cfg.autorearm, "autorearm toggle");
		fwd_cmd(OP_BLOCKS, 1, 8'd1, 8'h00);
		run_readout(1, 1'b1);

		// chip id, then the same request with the chain passed through
		tx_q.delete();
		send_cmd(OP_CHIP_ID, 0, 8'h00, 8'h00);
		expect_consumed();
		wait_reply(8, 500);
		for (int i = 0; i < 8 && i < tx_q.size(); i++)
			check(tx_q[i] == chip_id[8*i +: 8], $sformatf("chip id byte %0d is %02h", i, tx_q[i]));
		fwd_cmd(8'(OP_ACTIVE + 5), 0, 8'h00, 8'h00);
		check(chain.passthrough, "passthrough after another board made active");
		tx_q.delete();
		fwd_cmd(OP_CHIP_ID, 0, 8'h00, 8'h00);
		repeat (10) @(negedge clk);
		check(tx_q.size() == 0 && !u_dut.busy, "id reply sent while passthrough set");

		// capture never completes
		select_self(1'b0);
		check(u_dut.busy, "readout did not start");
		t = 0;
		while (u_dut.busy && t < TIMEOUT_CYCLES + 50) begin
			@(negedge clk);
			t++;
		end
		if (u_dut.busy)
			report_timeout("busy to fall after the capture wait gave up");
		check(t > TIMEOUT_CYCLES - 10, "capture wait gave up early");
		check(tx_q.size() == 0, "bytes sent without a capture");

		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#2_000_000;
		$display("simulation watchdog expired before the test finished");
		$display("errors: %0d, timeouts: %0d", errors, timeouts + 1);
		$display("Result: FAILED");
		$finish;
	end

endmodule
